// ==== vecProc_cfg.svh ====
`ifndef VEC_PROC_CFG_SVH
`define VEC_PROC_CFG_SVH

// Lane geometry of a vector register
`define VP_LANE_W 8
`define VP_LANES 4

// Registers of each kind, scalar and vector
`define VP_REGS 4

// Instruction memory words, one per PC value
`define VP_IMEM_DEPTH 256

// Vector data memory words
`define VP_DMEM_DEPTH 16

`endif

// ==== vecProcPkg.sv ====
`default_nettype none
`include "vecProc_cfg.svh"

package vecProcPkg;

    typedef logic [`VP_LANE_W-1:0] laneT;
    // Lane 0 in the low byte
    typedef logic [`VP_LANES*`VP_LANE_W-1:0] vecT;
    typedef logic [15:0] instrT;
    typedef logic [$clog2(`VP_IMEM_DEPTH)-1:0] pcT;
    // Bit 3 marks a vector register
    typedef logic [3:0] regSelT;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_LI  = 4'd6,
        OP_LD  = 4'd7,
        OP_ST  = 4'd8,
        OP_CMP = 4'd9,
        OP_JMP = 4'd10,
        OP_BZ  = 4'd11
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_PASS = 3'd5
    } aluOpT;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_MEM = 2'd2
    } wbSrcT;

    typedef struct packed {
        logic   memWrite;
        wbSrcT  wbSrc;
        regSelT rd;
        laneT   imm;
        logic   regWrite;
        logic   isBranch;
        logic   isJump;
        logic   setFlags;
        aluOpT  aluOp;
    } ctrlT;

    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        vecT  op1;
        vecT  op2;
    } decExT;

    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        logic pcWrite;
        vecT  result;
    } exWbT;

    typedef struct packed {
        regSelT rd;
        vecT    data;
    } retireT;

endpackage

`default_nettype wire

// ==== fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vecProc_cfg.svh"

module fetchStage import vecProcPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  run,
    input  logic  imemWe,
    input  pcT    imemAddr,
    input  instrT imemData,
    input  logic  pcWrite,
    input  pcT    pcTarget,
    output instrT instr
);

    instrT imem [`VP_IMEM_DEPTH];
    pcT pc;

    // Program load, only legal while halted
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    // Redirect from write-back wins over the increment
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            if (pcWrite) begin
                pc <= pcTarget;
            end else begin
                pc <= pc + pcT'(1);
            end
        end
    end

    assign instr = imem[pc];

endmodule

`default_nettype wire

// ==== decoderStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoderStage import vecProcPkg::*; (
    input  instrT  instr,
    output ctrlT   ctrl,
    output regSelT rs1,
    output regSelT rs2
);

    opcodeT opcode;

    assign opcode = opcodeT'(instr[15:12]);

    // Sources sit in the same bits in every format that reads them
    assign rs1 = instr[11:8];
    assign rs2 = instr[7:4];

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = ALU_PASS;
        ctrl.wbSrc = WB_ALU;
        ctrl.imm = instr[7:0];
        ctrl.rd = instr[3:0];
        case (opcode)
            OP_ADD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = ALU_ADD;
            end
            OP_SUB: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = ALU_SUB;
            end
            OP_AND: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = ALU_AND;
            end
            OP_OR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = ALU_OR;
            end
            OP_XOR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = ALU_XOR;
            end
            OP_LI: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSrc = WB_IMM;
                ctrl.rd = instr[11:8];
            end
            OP_LD: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSrc = WB_MEM;
                ctrl.rd = instr[11:8];
            end
            // Store data is rs1 passed through the ALU
            OP_ST: ctrl.memWrite = 1'b1;
            // Subtract only for the flags, nothing written
            OP_CMP: begin
                ctrl.setFlags = 1'b1;
                ctrl.aluOp = ALU_SUB;
            end
            OP_JMP: ctrl.isJump = 1'b1;
            OP_BZ: ctrl.isBranch = 1'b1;
            default: ctrl.regWrite = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vecProc_cfg.svh"

module regFile import vecProcPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  regSelT rs1,
    input  regSelT rs2,
    output vecT    op1,
    output vecT    op2,
    input  logic   we,
    input  regSelT wsel,
    input  vecT    wdata
);

    localparam int IdxW = $clog2(`VP_REGS);

    laneT sReg [`VP_REGS];
    vecT  vReg [`VP_REGS];

    // Scalars read back as lane 0 with upper lanes zero
    assign op1 = rs1[3] ? vReg[rs1[IdxW-1:0]] : vecT'(sReg[rs1[IdxW-1:0]]);
    assign op2 = rs2[3] ? vReg[rs2[IdxW-1:0]] : vecT'(sReg[rs2[IdxW-1:0]]);

    // No writes while reset is asserted
    always_ff @(posedge clk) begin
        if (we && arstN) begin
            if (wsel[3]) begin
                vReg[wsel[IdxW-1:0]] <= wdata;
            end else begin
                sReg[wsel[IdxW-1:0]] <= wdata[`VP_LANE_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vecProc_cfg.svh"

module executeStage import vecProcPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  run,
    input  decExT dIn,
    output exWbT  eOut
);

    localparam int W = `VP_LANE_W;

    vecT  aluRes;
    logic zFlag;
    logic takeBranch;
    exWbT eNext;

    // Lanewise, carries never cross into the next lane
    always_comb begin
        laneT a;
        laneT b;
        aluRes = '0;
        for (int i = 0; i < `VP_LANES; i++) begin
            a = dIn.op1[i*W +: W];
            b = dIn.op2[i*W +: W];
            case (dIn.ctrl.aluOp)
                ALU_ADD: aluRes[i*W +: W] = a + b;
                ALU_SUB: aluRes[i*W +: W] = a - b;
                ALU_AND: aluRes[i*W +: W] = a & b;
                ALU_OR:  aluRes[i*W +: W] = a | b;
                ALU_XOR: aluRes[i*W +: W] = a ^ b;
                default: aluRes[i*W +: W] = a;
            endcase
        end
    end

    // BZ reads the registered Z, so a CMP just before it is already visible
    assign takeBranch = dIn.valid && (dIn.ctrl.isJump || (dIn.ctrl.isBranch && zFlag));

    always_comb begin
        eNext = '0;
        eNext.valid = dIn.valid;
        eNext.ctrl = dIn.ctrl;
        eNext.ctrl.regWrite = dIn.ctrl.regWrite && dIn.valid;
        eNext.ctrl.memWrite = dIn.ctrl.memWrite && dIn.valid;
        eNext.pcWrite = takeBranch;
        eNext.result = aluRes;
    end

    // Z comes from lane 0 only
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            zFlag <= 1'b0;
        end else if (run && dIn.valid && dIn.ctrl.setFlags) begin
            zFlag <= (aluRes[W-1:0] == '0);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            eOut <= '0;
        end else if (run) begin
            eOut <= eNext;
        end
    end

endmodule

`default_nettype wire

// ==== writebackStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vecProc_cfg.svh"

module writebackStage import vecProcPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    input  exWbT   wIn,
    output logic   we,
    output regSelT wsel,
    output vecT    wdata,
    output logic   pcWrite,
    output pcT     pcTarget,
    output logic   retireValid,
    output retireT retire
);

    localparam int W = `VP_LANE_W;
    localparam int AddrW = $clog2(`VP_DMEM_DEPTH);

    vecT dmem [`VP_DMEM_DEPTH];
    logic [AddrW-1:0] dAddr;
    logic commit;
    vecT wbVal;

    assign dAddr = wIn.ctrl.imm[AddrW-1:0];
    // Nothing commits while halted
    assign commit = run && wIn.valid;

    always_ff @(posedge clk) begin
        if (arstN && commit && wIn.ctrl.memWrite) begin
            dmem[dAddr] <= wIn.result;
        end
    end

    // Immediate goes to every lane, scalar masking below trims it
    always_comb begin
        case (wIn.ctrl.wbSrc)
            WB_IMM:  wbVal = {`VP_LANES{wIn.ctrl.imm}};
            WB_MEM:  wbVal = dmem[dAddr];
            default: wbVal = wIn.result;
        endcase
    end

    // Scalar destinations keep lane 0
    assign wdata = wIn.ctrl.rd[3] ? wbVal : vecT'(wbVal[W-1:0]);
    assign we = commit && wIn.ctrl.regWrite;
    assign wsel = wIn.ctrl.rd;

    assign pcWrite = commit && wIn.pcWrite;
    assign pcTarget = pcT'(wIn.ctrl.imm);

    assign retireValid = we;
    assign retire = '{rd: wIn.ctrl.rd, data: wdata};

endmodule

`default_nettype wire

// ==== vecProcessor.sv ====
`timescale 1ns/1ps
`default_nettype none

module vecProcessor import vecProcPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    input  logic   imemWe,
    input  pcT     imemAddr,
    input  instrT  imemData,
    output logic   retireValid,
    output retireT retire
);

    instrT  fInstr;
    instrT  fdInstr;
    logic   fdValid;
    ctrlT   dCtrl;
    regSelT rs1;
    regSelT rs2;
    vecT    op1;
    vecT    op2;
    decExT  deReg;
    exWbT   exWb;
    logic   we;
    regSelT wsel;
    vecT    wdata;
    logic   pcWrite;
    pcT     pcTarget;

    fetchStage fetchInst (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .pcWrite  (pcWrite),
        .pcTarget (pcTarget),
        .instr    (fInstr)
    );

    // F/D register, valid rises with the first running cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fdInstr <= '0;
            fdValid <= 1'b0;
        end else if (run) begin
            fdInstr <= fInstr;
            fdValid <= 1'b1;
        end
    end

    decoderStage decodeInst (
        .instr (fdInstr),
        .ctrl  (dCtrl),
        .rs1   (rs1),
        .rs2   (rs2)
    );

    regFile regFileInst (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (rs1),
        .rs2   (rs2),
        .op1   (op1),
        .op2   (op2),
        .we    (we),
        .wsel  (wsel),
        .wdata (wdata)
    );

    // D/E register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            deReg <= '0;
        end else if (run) begin
            deReg <= '{valid: fdValid, ctrl: dCtrl, op1: op1, op2: op2};
        end
    end

    executeStage executeInst (
        .clk   (clk),
        .arstN (arstN),
        .run   (run),
        .dIn   (deReg),
        .eOut  (exWb)
    );

    writebackStage writebackInst (
        .clk         (clk),
        .arstN       (arstN),
        .run         (run),
        .wIn         (exWb),
        .we          (we),
        .wsel        (wsel),
        .wdata       (wdata),
        .pcWrite     (pcWrite),
        .pcTarget    (pcTarget),
        .retireValid (retireValid),
        .retire      (retire)
    );

endmodule

`default_nettype wire

// ==== vecProcessor_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module vecProcessor_assertions import vecProcPkg::*; (
    input logic   clk,
    input logic   arstN,
    input logic   retireValid,
    input retireT retire,
    input logic   pcWrite
);

    retireQuietInReset: assert property (@(posedge clk) !arstN |-> !retireValid)
        else $error("retireValid high while reset is asserted");

    retireKnown: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> !$isunknown(retire))
        else $error("retire has unknown bits while retireValid is high");

    // pcWrite already includes run, so only running cycles count
    noBackToBackRedirect: assert property (@(posedge clk) disable iff (!arstN)
        pcWrite |=> !pcWrite)
        else $error("pcWrite high on two consecutive running cycles");

endmodule

bind vecProcessor vecProcessor_assertions assertInst (
    .clk         (clk),
    .arstN       (arstN),
    .retireValid (retireValid),
    .retire      (retire),
    .pcWrite     (pcWrite)
);

`default_nettype wire

// ==== tb_vecProcessor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vecProcessor import vecProcPkg::*; ();

    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 16;
    localparam int ProgLen = 40;
    localparam int NumRuns = 5;
    // Reset, load and a run stretched by halts, per program run
    localparam int RunCycles = ResetCycles + ProgLen + 4 * ProgLen;
    localparam int MaxCycles = NumRuns * RunCycles + 200;

    localparam instrT NopWord = 16'h0000;
    localparam regSelT S0 = 4'h0;
    localparam regSelT S1 = 4'h1;
    localparam regSelT S2 = 4'h2;
    localparam regSelT V0 = 4'h8;
    localparam regSelT V1 = 4'h9;
    localparam regSelT V2 = 4'ha;
    localparam regSelT V3 = 4'hb;

    logic   clk;
    logic   arstN;
    logic   run;
    logic   imemWe;
    pcT     imemAddr;
    instrT  imemData;
    logic   retireValid;
    retireT retire;

    logic [31:0] rngState;
    int     errCount;
    int     checkCount;
    instrT  prog[$];
    regSelT expRd[$];
    vecT    expData[$];
    regSelT gotRd[$];
    vecT    gotData[$];

    vecProcessor dut_i (
        .clk         (clk),
        .arstN       (arstN),
        .run         (run),
        .imemWe      (imemWe),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .retireValid (retireValid),
        .retire      (retire)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (arstN && retireValid) begin
            if (!run) begin
                $display("retire of rd %h seen while run is low", retire.rd);
                errCount++;
            end
            gotRd.push_back(retire.rd);
            gotData.push_back(retire.data);
        end
    end

    initial begin
        #(MaxCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, a program never finished", MaxCycles);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] s;
        s = rngState;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        rngState = s;
        return s;
    endfunction

    function automatic instrT rInstr(opcodeT op, regSelT a, regSelT b, regSelT d);
        return {op, a, b, d};
    endfunction

    function automatic instrT iInstr(opcodeT op, regSelT r, laneT imm);
        return {op, r, imm};
    endfunction

    function automatic vecT splat(laneT b);
        return {b, b, b, b};
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic addExpected(input regSelT rd, input vecT data);
        expRd.push_back(rd);
        expData.push_back(data);
    endtask

    task automatic newProgram();
        prog.delete();
        expRd.delete();
        expData.delete();
    endtask

    task automatic resetDut();
        run <= 1'b0;
        arstN <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
    endtask

    // Pads with NOPs so the drain never fetches unwritten words
    task automatic loadProgram();
        for (int a = 0; a < ProgLen; a++) begin
            @(posedge clk);
            imemWe <= 1'b1;
            imemAddr <= pcT'(a);
            imemData <= (a < prog.size()) ? prog[a] : NopWord;
        end
        @(posedge clk);
        imemWe <= 1'b0;
    endtask

    task automatic runProgram(input bit halts);
        int hold;
        resetDut();
        loadProgram();
        gotRd.delete();
        gotData.delete();
        @(posedge clk);
        run <= 1'b1;
        while (gotRd.size() < expRd.size()) begin
            @(posedge clk);
            if (halts && nextRand() % 32'd4 == 32'd0) begin
                run <= 1'b0;
                hold = 1 + int'(nextRand() % 32'd6);
                repeat (hold) @(posedge clk);
                run <= 1'b1;
            end
        end
        // Trailing NOPs must not retire
        repeat (4) @(posedge clk);
        run <= 1'b0;
        @(posedge clk);
    endtask

    task automatic compareRetires();
        int n;
        checkEq("retire count", 32'(gotRd.size()), 32'(expRd.size()));
        n = (gotRd.size() < expRd.size()) ? gotRd.size() : expRd.size();
        for (int i = 0; i < n; i++) begin
            checkEq("retire.rd", 32'(gotRd[i]), 32'(expRd[i]));
            checkEq("retire.data", gotData[i], expData[i]);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("test %s finished with %0d errors", name, errCount - errBefore);
    endtask

    task automatic testAlu();
        int errBefore;
        laneT a;
        laneT b;
        errBefore = errCount;
        newProgram();
        a = laneT'(nextRand());
        b = laneT'(nextRand());
        prog.push_back(iInstr(OP_LI, V0, a));
        prog.push_back(iInstr(OP_LI, V1, b));
        prog.push_back(NopWord);
        prog.push_back(NopWord);
        prog.push_back(rInstr(OP_ADD, V0, V1, V2));
        prog.push_back(rInstr(OP_SUB, V0, V1, V3));
        prog.push_back(rInstr(OP_AND, V0, V1, V2));
        prog.push_back(rInstr(OP_OR, V0, V1, V3));
        prog.push_back(rInstr(OP_XOR, V0, V1, V2));
        addExpected(V0, splat(a));
        addExpected(V1, splat(b));
        addExpected(V2, splat(laneT'(a + b)));
        addExpected(V3, splat(laneT'(a - b)));
        addExpected(V2, splat(a & b));
        addExpected(V3, splat(a | b));
        addExpected(V2, splat(a ^ b));
        runProgram(1'b0);
        compareRetires();
        reportTest("lanewise ALU", errBefore);
    endtask

    task automatic testScalarVector();
        int errBefore;
        laneT c;
        laneT d;
        errBefore = errCount;
        newProgram();
        c = laneT'(nextRand());
        d = laneT'(nextRand());
        prog.push_back(iInstr(OP_LI, S1, c));
        prog.push_back(iInstr(OP_LI, V2, d));
        prog.push_back(NopWord);
        prog.push_back(NopWord);
        prog.push_back(rInstr(OP_ADD, S1, V2, V3));
        prog.push_back(rInstr(OP_ADD, V2, V2, S0));
        addExpected(S1, vecT'(c));
        addExpected(V2, splat(d));
        // Scalar operand has zero upper lanes
        addExpected(V3, {d, d, d, laneT'(c + d)});
        addExpected(S0, vecT'(laneT'(d + d)));
        runProgram(1'b0);
        compareRetires();
        reportTest("scalar and vector", errBefore);
    endtask

    task automatic testMemory();
        int errBefore;
        laneT a;
        laneT c;
        logic [3:0] addrA;
        logic [3:0] addrB;
        vecT mixed;
        errBefore = errCount;
        newProgram();
        a = laneT'(nextRand());
        c = laneT'(nextRand());
        addrA = 4'(nextRand());
        addrB = addrA ^ 4'h8;
        mixed = {a, a, a, laneT'(a + c)};
        prog.push_back(iInstr(OP_LI, V0, a));
        prog.push_back(iInstr(OP_LI, S1, c));
        prog.push_back(NopWord);
        prog.push_back(NopWord);
        prog.push_back(rInstr(OP_ADD, S1, V0, V1));
        prog.push_back(NopWord);
        prog.push_back(NopWord);
        prog.push_back(iInstr(OP_ST, V1, {4'h0, addrA}));
        prog.push_back(iInstr(OP_ST, V0, {4'h0, addrB}));
        prog.push_back(iInstr(OP_LD, V2, {4'h0, addrA}));
        prog.push_back(iInstr(OP_LD, V3, {4'h0, addrB}));
        addExpected(V0, splat(a));
        addExpected(S1, vecT'(c));
        addExpected(V1, mixed);
        addExpected(V2, mixed);
        addExpected(V3, splat(a));
        runProgram(1'b0);
        compareRetires();
        reportTest("data memory", errBefore);
    endtask

    // JMP, a taken BZ and a BZ that falls through, each with three delay slots
    task automatic buildBranchProgram();
        newProgram();
        prog.push_back(iInstr(OP_LI, S0, 8'h05));
        prog.push_back(iInstr(OP_LI, S1, 8'h05));
        prog.push_back(iInstr(OP_LI, S2, 8'h07));
        prog.push_back(NopWord);
        prog.push_back(iInstr(OP_JMP, 4'h0, 8'd10));
        prog.push_back(iInstr(OP_LI, V0, 8'h11));
        prog.push_back(iInstr(OP_LI, V1, 8'h12));
        prog.push_back(iInstr(OP_LI, V2, 8'h13));
        prog.push_back(iInstr(OP_LI, V3, 8'hee));
        prog.push_back(iInstr(OP_LI, V3, 8'hef));
        prog.push_back(rInstr(OP_CMP, S0, S1, 4'h0));
        prog.push_back(iInstr(OP_BZ, 4'h0, 8'd16));
        prog.push_back(iInstr(OP_LI, V0, 8'h21));
        prog.push_back(iInstr(OP_LI, V1, 8'h22));
        prog.push_back(iInstr(OP_LI, V2, 8'h23));
        prog.push_back(iInstr(OP_LI, V3, 8'hee));
        prog.push_back(rInstr(OP_CMP, S0, S2, 4'h0));
        prog.push_back(iInstr(OP_BZ, 4'h0, 8'd30));
        prog.push_back(iInstr(OP_LI, V0, 8'h31));
        prog.push_back(iInstr(OP_LI, V1, 8'h32));
        prog.push_back(iInstr(OP_LI, V2, 8'h33));
        prog.push_back(iInstr(OP_LI, V3, 8'h34));
        addExpected(S0, vecT'(8'h05));
        addExpected(S1, vecT'(8'h05));
        addExpected(S2, vecT'(8'h07));
        addExpected(V0, splat(8'h11));
        addExpected(V1, splat(8'h12));
        addExpected(V2, splat(8'h13));
        addExpected(V0, splat(8'h21));
        addExpected(V1, splat(8'h22));
        addExpected(V2, splat(8'h23));
        addExpected(V0, splat(8'h31));
        addExpected(V1, splat(8'h32));
        addExpected(V2, splat(8'h33));
        addExpected(V3, splat(8'h34));
    endtask

    task automatic testBranch();
        int errBefore;
        errBefore = errCount;
        buildBranchProgram();
        runProgram(1'b0);
        compareRetires();
        reportTest("control flow", errBefore);
    endtask

    task automatic testHalt();
        int errBefore;
        errBefore = errCount;
        // Same sequence as the unhalted branch program
        buildBranchProgram();
        runProgram(1'b1);
        compareRetires();
        reportTest("halting", errBefore);
    endtask

    initial begin
        clk = 1'b0;
        arstN <= 1'b0;
        run <= 1'b0;
        imemWe <= 1'b0;
        imemAddr <= '0;
        imemData <= '0;
        rngState = 32'h00920d18;
        errCount = 0;
        checkCount = 0;
        testAlu();
        testScalarVector();
        testMemory();
        testBranch();
        testHalt();
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vecProcessor.f ====
+incdir+.
vecProcPkg.sv
fetchStage.sv
decoderStage.sv
regFile.sv
executeStage.sv
writebackStage.sv
vecProcessor.sv
vecProcessor_assertions.sv
tb_vecProcessor.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vecProcessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f vecProcessor.f \
    --top-module tb_vecProcessor \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
